//--- source/perf_pkg.sv
package perf_pkg;

	// event groups
	localparam int L1_EVENTS = 5;
	localparam int L2_EVENTS = 3;

	// serial link and report timing, in clock cycles
	localparam int BAUD_DIV = 16;
	localparam int FRAME_BITS = 10; // start + 8 data + stop
	localparam int REPORT_PERIOD = 1200;
	localparam int REPORT_BYTES = 6;

	localparam int BAUD_W = $clog2(BAUD_DIV);
	localparam int FRAME_CNT_W = $clog2(FRAME_BITS);
	localparam int PERIOD_W = $clog2(REPORT_PERIOD);
	localparam int REPORT_IDX_W = $clog2(REPORT_BYTES);

	typedef logic [7:0] cnt_t; // wraps at 256

	// first member is the msb of the packed vector
	typedef struct packed {
		logic i_read;
		logic i_miss;
		logic d_read;
		logic d_write;
		logic d_miss;
	} l1_event_t;

	typedef struct packed {
		logic read;
		logic write;
		logic miss;
	} l2_event_t;

	// count positions follow the bit positions of the event structs
	localparam int L1_I_READ = 4;
	localparam int L1_I_MISS = 3;
	localparam int L1_D_READ = 2;
	localparam int L1_D_WRITE = 1;
	localparam int L1_D_MISS = 0;

	localparam int L2_READ = 2;
	localparam int L2_WRITE = 1;
	localparam int L2_MISS = 0;

	typedef cnt_t [L1_EVENTS-1:0] l1_counts_t;
	typedef cnt_t [L2_EVENTS-1:0] l2_counts_t;

endpackage

//--- source/event_counter_bank.sv
module event_counter_bank #(
	parameter type event_t = logic,
	parameter int N_EVENTS = 1
) (
	input logic clk,
	input logic rstn,
	input event_t events,
	output perf_pkg::cnt_t [N_EVENTS-1:0] counts
);
	import perf_pkg::*;

	logic [N_EVENTS-1:0] strobe;
	logic [N_EVENTS-1:0] strobe_d;
	logic [N_EVENTS-1:0] rise;
	cnt_t [N_EVENTS-1:0] cnt_q;

	// the struct is flattened so that bit i drives count i
	assign strobe = events;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			strobe_d <= '0;
		end else begin
			strobe_d <= strobe;
		end
	end

	// a strobe held high gives a single rise
	assign rise = strobe & ~strobe_d;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			cnt_q <= '0;
		end else begin
			for (int i = 0; i < N_EVENTS; i++) begin
				if (rise[i]) begin
					cnt_q[i] <= cnt_q[i] + 1'b1; // free running, wraps
				end
			end
		end
	end

	assign counts = cnt_q;

endmodule

//--- source/report_sequencer.sv
module report_sequencer (
	input logic clk,
	input logic rstn,
	input perf_pkg::l1_counts_t l1_counts,
	input perf_pkg::l2_counts_t l2_counts,
	input logic tx_busy,
	output perf_pkg::cnt_t tx_data,
	output logic tx_start,
	output logic report_busy
);
	import perf_pkg::*;

	logic [PERIOD_W-1:0] period_cnt;
	logic snapshot;
	cnt_t [REPORT_BYTES-1:0] report_d;
	cnt_t [REPORT_BYTES-1:0] report_q;
	logic [REPORT_IDX_W-1:0] byte_idx;
	logic sending;
	logic last_byte;

	assign snapshot = (period_cnt == PERIOD_W'(REPORT_PERIOD - 1));

	always_ff @(posedge clk) begin
		if (!rstn) begin
			period_cnt <= '0;
		end else if (snapshot) begin
			period_cnt <= '0;
		end else begin
			period_cnt <= period_cnt + 1'b1;
		end
	end

	// report layout: miss byte first, then the matching access byte
	always_comb begin
		report_d[0] = l1_counts[L1_I_MISS];
		report_d[1] = l1_counts[L1_I_READ];
		report_d[2] = l1_counts[L1_D_MISS];
		report_d[3] = l1_counts[L1_D_READ] + l1_counts[L1_D_WRITE]; // mod 256
		report_d[4] = l2_counts[L2_MISS];
		report_d[5] = l2_counts[L2_READ] + l2_counts[L2_WRITE]; // mod 256
	end

	always_ff @(posedge clk) begin
		if (snapshot) begin
			report_q <= report_d;
		end
	end

	assign last_byte = (byte_idx == REPORT_IDX_W'(REPORT_BYTES - 1));

	// busy rises the cycle after a start, so no extra wait state is needed
	assign tx_start = sending & ~tx_busy;
	assign tx_data = report_q[byte_idx];

	always_ff @(posedge clk) begin
		if (!rstn) begin
			sending <= 1'b0;
			byte_idx <= '0;
			report_busy <= 1'b0;
		end else if (snapshot) begin
			sending <= 1'b1;
			byte_idx <= '0;
			report_busy <= 1'b1;
		end else begin
			if (tx_start) begin
				if (last_byte) begin
					sending <= 1'b0;
				end else begin
					byte_idx <= byte_idx + 1'b1;
				end
			end
			// last frame has left the transmitter
			if (!sending && !tx_busy) begin
				report_busy <= 1'b0;
			end
		end
	end

endmodule

//--- source/uart_tx.sv
module uart_tx (
	input logic clk,
	input logic rstn,
	input logic [7:0] tx_data,
	input logic tx_start,
	output logic tx_busy,
	output logic txd
);
	import perf_pkg::*;

	logic accept;
	logic [BAUD_W-1:0] baud_cnt;
	logic [FRAME_CNT_W-1:0] bit_cnt;
	logic [8:0] shift_q; // stop bit above the data byte
	logic bit_end;
	logic frame_end;

	assign accept = tx_start & ~tx_busy;
	assign bit_end = (baud_cnt == BAUD_W'(BAUD_DIV - 1));
	assign frame_end = bit_end && (bit_cnt == FRAME_CNT_W'(FRAME_BITS - 1));

	always_ff @(posedge clk) begin
		if (accept) begin
			shift_q <= {1'b1, tx_data};
		end else if (tx_busy && bit_end) begin
			shift_q <= {1'b1, shift_q[8:1]}; // lsb first
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			tx_busy <= 1'b0;
			baud_cnt <= '0;
			bit_cnt <= '0;
			txd <= 1'b1;
		end else if (accept) begin
			tx_busy <= 1'b1;
			baud_cnt <= '0;
			bit_cnt <= '0;
			txd <= 1'b0; // start bit
		end else if (tx_busy) begin
			if (bit_end) begin
				baud_cnt <= '0;
				if (frame_end) begin
					tx_busy <= 1'b0;
					txd <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
					txd <= shift_q[0];
				end
			end else begin
				baud_cnt <= baud_cnt + 1'b1;
			end
		end
	end

endmodule

//--- source/cache_perf_monitor.sv
module cache_perf_monitor (
	input logic clk,
	input logic rstn,
	input logic read_l1i,
	input logic miss_l1i,
	input logic read_l1d,
	input logic write_l1d,
	input logic miss_l1d,
	input logic read_l2,
	input logic write_l2,
	input logic miss_l2,
	output logic txd,
	output logic report_busy
);
	import perf_pkg::*;

	l1_event_t l1_events;
	l2_event_t l2_events;
	l1_counts_t l1_counts;
	l2_counts_t l2_counts;
	cnt_t tx_data;
	logic tx_start;
	logic tx_busy;

	assign l1_events = '{
		i_read: read_l1i,
		i_miss: miss_l1i,
		d_read: read_l1d,
		d_write: write_l1d,
		d_miss: miss_l1d
	};

	assign l2_events = '{
		read: read_l2,
		write: write_l2,
		miss: miss_l2
	};

	event_counter_bank #(
		.event_t(l1_event_t),
		.N_EVENTS(L1_EVENTS)
	) l1_bank (
		.clk(clk),
		.rstn(rstn),
		.events(l1_events),
		.counts(l1_counts)
	);

	event_counter_bank #(
		.event_t(l2_event_t),
		.N_EVENTS(L2_EVENTS)
	) l2_bank (
		.clk(clk),
		.rstn(rstn),
		.events(l2_events),
		.counts(l2_counts)
	);

	report_sequencer u_seq (
		.clk(clk),
		.rstn(rstn),
		.l1_counts(l1_counts),
		.l2_counts(l2_counts),
		.tx_busy(tx_busy),
		.tx_data(tx_data),
		.tx_start(tx_start),
		.report_busy(report_busy)
	);

	uart_tx u_tx (
		.clk(clk),
		.rstn(rstn),
		.tx_data(tx_data),
		.tx_start(tx_start),
		.tx_busy(tx_busy),
		.txd(txd)
	);

endmodule

//--- tb/cache_perf_monitor_properties.sv
module cache_perf_monitor_properties (
	input logic clk,
	input logic rstn,
	input logic txd,
	input logic tx_busy,
	input logic tx_start,
	input perf_pkg::l1_counts_t l1_counts,
	input perf_pkg::l2_counts_t l2_counts
);
	timeunit 1ns;
	timeprecision 1ns;

	import perf_pkg::*;

	idle_line_high: assert property (@(posedge clk) disable iff (!rstn) !tx_busy |-> txd)
		else $error("txd low while the transmitter is idle");

	no_start_when_busy: assert property (@(posedge clk) disable iff (!rstn) tx_busy |-> !tx_start)
		else $error("tx_start raised while tx_busy is high");

	start_one_cycle: assert property (@(posedge clk) disable iff (!rstn) tx_start |=> !tx_start)
		else $error("tx_start held for more than one cycle");

	// difference taken modulo 256 so a wrap counts as a step of one
	for (genvar i = 0; i < L1_EVENTS; i++) begin : g_l1_step
		l1_step: assert property (@(posedge clk) disable iff (!rstn)
			cnt_t'(l1_counts[i] - $past(l1_counts[i])) <= 8'd1)
			else $error("l1 count %0d rose by more than one", i);
	end

	for (genvar i = 0; i < L2_EVENTS; i++) begin : g_l2_step
		l2_step: assert property (@(posedge clk) disable iff (!rstn)
			cnt_t'(l2_counts[i] - $past(l2_counts[i])) <= 8'd1)
			else $error("l2 count %0d rose by more than one", i);
	end

endmodule

bind cache_perf_monitor cache_perf_monitor_properties u_props (
	.clk(clk),
	.rstn(rstn),
	.txd(txd),
	.tx_busy(tx_busy),
	.tx_start(tx_start),
	.l1_counts(l1_counts),
	.l2_counts(l2_counts)
);

//--- tb/cache_perf_monitor_tb.sv
module cache_perf_monitor_tb;
	timeunit 1ns;
	timeprecision 1ns;

	import perf_pkg::*;

	localparam int WIN_LO = 100; // event window inside each period
	localparam int WIN_HI = REPORT_PERIOD - 100;
	localparam int N_REPORTS = 4;
	localparam int TIMEOUT_CYCLES = 5 * REPORT_PERIOD + 500;

	typedef logic [REPORT_BYTES-1:0][7:0] report_t;

	logic clk;
	logic rstn;
	logic [7:0] ev; // read_l1i, miss_l1i, read_l1d, write_l1d, miss_l1d, read_l2, write_l2, miss_l2
	logic txd;
	logic report_busy;

	logic [7:0][7:0] model_cnt; // same bit order as ev
	report_t exp_q[$];
	logic [7:0] rx_q[$];
	integer seed;
	int cycle;
	int rx_count;
	int last_stop_cycle;
	int frame_errs;
	int errors;
	int tests_run;
	int tests_failed;
	logic reports_done;
	logic busy_done;

	cache_perf_monitor dut0 (
		.clk(clk),
		.rstn(rstn),
		.read_l1i(ev[0]),
		.miss_l1i(ev[1]),
		.read_l1d(ev[2]),
		.write_l1d(ev[3]),
		.miss_l1d(ev[4]),
		.read_l2(ev[5]),
		.write_l2(ev[6]),
		.miss_l2(ev[7]),
		.txd(txd),
		.report_busy(report_busy)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAIL");
			$finish;
		end
	end

	// miss byte then access byte for L1I, L1D and L2, sums wrap at 256
	function automatic report_t expected_report(input logic [7:0][7:0] cnt);
		report_t r;
		r[0] = cnt[1];
		r[1] = cnt[0];
		r[2] = cnt[4];
		r[3] = cnt[2] + cnt[3];
		r[4] = cnt[7];
		r[5] = cnt[5] + cnt[6];
		return r;
	endfunction

	// strobe s gets s+1 single-cycle pulses, write_l1d is also held high for a while
	function automatic logic [7:0] directed_events(input int c);
		logic [7:0] v;
		int k;
		v = '0;
		for (int s = 0; s < 8; s++) begin
			k = c - (WIN_LO + 40 * s);
			if (k >= 0 && k < 4 * (s + 1) && k % 4 == 0)
				v[s] = 1'b1;
		end
		if (c >= 600 && c < 900)
			v[3] = 1'b1; // counts once
		return v;
	endfunction

	function automatic string report_title(input int n);
		case (n)
			0: return "idle report, all counts zero";
			1: return "single pulses and a held strobe";
			2: return "counts and sums wrap past 256";
			default: return "random strobes, cumulative counts";
		endcase
	endfunction

	task automatic count_rises(input logic [7:0] nxt);
		for (int i = 0; i < 8; i++) begin
			if (nxt[i] && !ev[i])
				model_cnt[i] = model_cnt[i] + 8'd1;
		end
	endtask

	task automatic run_period(input int p);
		logic [7:0] nxt;
		int r;
		for (int c = 0; c < REPORT_PERIOD; c++) begin
			@(posedge clk);
			nxt = '0;
			if (c >= WIN_LO && c < WIN_HI) begin
				case (p)
					1: nxt = directed_events(c);
					2: begin
						nxt[2] = (c % 2 == 0); // 500 rises on read_l1d
						nxt[3] = (c % 4 == 0);
						nxt[5] = (c % 5 == 0);
						nxt[6] = (c % 3 == 0);
						nxt[7] = (c % 6 == 0);
					end
					3: begin
						r = $random(seed);
						nxt = (r[2:0] == 3'd0) ? r[15:8] : ev; // hold gives multi-cycle highs
					end
					default: nxt = '0;
				endcase
			end
			count_rises(nxt);
			ev <= nxt;
			if (c == WIN_HI + 50)
				exp_q.push_back(expected_report(model_cnt));
		end
	endtask

	initial begin : serial_receive
		logic [7:0] data;
		@(posedge rstn);
		forever begin
			@(negedge clk);
			if (txd === 1'b0) begin
				repeat (BAUD_DIV / 2 - 1) @(negedge clk); // middle of the start bit
				if (txd !== 1'b0) begin
					$display("FAIL %0t: start bit did not hold low", $time);
					errors++;
					frame_errs++;
				end
				for (int i = 0; i < 8; i++) begin
					repeat (BAUD_DIV) @(negedge clk);
					data[i] = txd;
				end
				repeat (BAUD_DIV) @(negedge clk);
				if (txd !== 1'b1) begin
					$display("FAIL %0t: stop bit is not high", $time);
					errors++;
					frame_errs++;
				end
				last_stop_cycle = cycle;
				rx_q.push_back(data);
				rx_count++;
			end
		end
	end

	initial begin : compare_bytes
		report_t exp_rep;
		logic [7:0] got;
		int rep_errs;
		int frame_base;
		for (int n = 0; n < N_REPORTS; n++) begin
			frame_base = frame_errs;
			while (exp_q.size() == 0)
				@(negedge clk);
			exp_rep = exp_q.pop_front();
			rep_errs = 0;
			for (int b = 0; b < REPORT_BYTES; b++) begin
				while (rx_q.size() == 0)
					@(negedge clk);
				got = rx_q.pop_front();
				if (got !== exp_rep[b]) begin
					$display("FAIL %0t: report %0d byte %0d is %02h, expected %02h",
						$time, n + 1, b, got, exp_rep[b]);
					errors++;
					rep_errs++;
				end
			end
			rep_errs += frame_errs - frame_base; // bad start or stop bits in this report
			tests_run++;
			if (rep_errs != 0)
				tests_failed++;
			$display("test %0d, %s: %s", n + 1, report_title(n), (rep_errs == 0) ? "ok" : "failed");
		end
		reports_done = 1'b1;
	end

	initial begin : check_busy_window
		int low_cycles;
		int busy_errs;
		low_cycles = 0;
		busy_errs = 0;
		@(posedge rstn);
		@(negedge clk);
		while (report_busy !== 1'b1) begin
			if (txd !== 1'b1) begin
				$display("FAIL %0t: txd left idle before the first report", $time);
				busy_errs++;
			end
			low_cycles++;
			@(negedge clk);
		end
		if (low_cycles != REPORT_PERIOD) begin
			$display("FAIL %0t: report_busy rose after %0d cycles, expected %0d",
				$time, low_cycles, REPORT_PERIOD);
			busy_errs++;
		end
		while (report_busy === 1'b1)
			@(negedge clk);
		if (rx_count != REPORT_BYTES) begin
			$display("FAIL %0t: report_busy fell after %0d bytes", $time, rx_count);
			busy_errs++;
		end else if (cycle - last_stop_cycle <= BAUD_DIV / 2) begin
			$display("FAIL %0t: report_busy fell before the last stop bit ended", $time);
			busy_errs++;
		end else if (cycle - last_stop_cycle > BAUD_DIV) begin
			$display("FAIL %0t: report_busy fell %0d cycles after the last stop bit",
				$time, cycle - last_stop_cycle);
			busy_errs++;
		end
		errors += busy_errs;
		tests_run++;
		if (busy_errs != 0)
			tests_failed++;
		$display("test idle line and report_busy window: %s", (busy_errs == 0) ? "ok" : "failed");
		busy_done = 1'b1;
	end

	initial begin
		clk = 1'b0;
		rstn = 1'b0;
		ev = '0;
		model_cnt = '0;
		seed = 32'hccd5cc88;
		cycle = 0;
		rx_count = 0;
		last_stop_cycle = 0;
		frame_errs = 0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		reports_done = 1'b0;
		busy_done = 1'b0;
		repeat (2) @(posedge clk);
		rstn <= 1'b1;
		for (int p = 0; p < N_REPORTS; p++)
			run_period(p);
		while (!(reports_done && busy_done))
			@(negedge clk);
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

//--- sources.f
source/perf_pkg.sv
source/event_counter_bank.sv
source/report_sequencer.sv
source/uart_tx.sv
source/cache_perf_monitor.sv
tb/cache_perf_monitor_properties.sv
tb/cache_perf_monitor_tb.sv

//--- Bender.yml
package:
  name: cache_perf_monitor

sources:
  # package first, then the RTL in dependency order
  - files:
      - source/perf_pkg.sv
      - source/event_counter_bank.sv
      - source/report_sequencer.sv
      - source/uart_tx.sv
      - source/cache_perf_monitor.sv

  # testbench, assertions bound into cache_perf_monitor
  - target: test
    files:
      - tb/cache_perf_monitor_properties.sv
      - tb/cache_perf_monitor_tb.sv
